// File: source/commit_pkg.sv
// Commit-side widths, program counter type and default sizes of the trace path

package commit_pkg;

  // --------------------------------------------------------------------------
  // Program counter
  // --------------------------------------------------------------------------

  // Width of a committed program counter
  localparam int unsigned XLEN = 64;

  typedef logic [XLEN-1:0] pc_t;

  // --------------------------------------------------------------------------
  // Default sizes of the commit trace
  // --------------------------------------------------------------------------

  // Instructions the commit stage can retire per cycle
  localparam int unsigned DefaultNrCommitPorts = 2;

  // Entries held per commit port before new program counters are dropped
  localparam int unsigned DefaultPcQueueDepth = 16;

endpackage

// File: source/perf_pkg.sv
// Performance counter address map, counter width and address width

package perf_pkg;

  // Width of the counter select field
  localparam int unsigned PerfAddrWidth = 3;

  // Full 64-bit counters, as seen through the CSR window
  localparam int unsigned PerfCntWidth = 64;

  typedef logic [PerfCntWidth-1:0] perf_cnt_t;

  // --------------------------------------------------------------------------
  // Counter addresses
  // --------------------------------------------------------------------------

  // Addresses 5 to 7 are unused and read as zero
  typedef enum logic [PerfAddrWidth-1:0] {
    PERF_CYCLE      = 3'd0,
    PERF_INSTRET    = 3'd1,
    PERF_EXCEPTION  = 3'd2,
    PERF_ERET       = 3'd3,
    PERF_TRACE_DROP = 3'd4
  } perf_addr_e;

endpackage

// File: source/pc_queue.sv
// Per-port circular FIFO of committed program counters with overflow pulse
`timescale 1ns/1ps

module pc_queue import commit_pkg::*; #(
  parameter int unsigned Depth = DefaultPcQueueDepth
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  pc_t  pc_i,
  input  logic pop_i,
  output pc_t  head_pc_o,
  output logic not_empty_o,
  output logic overflow_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  pc_t                 mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full;
  logic                push_ok;
  logic                pop_ok;

  // Wrap at Depth, which need not be a power of two
  function automatic logic [PtrWidth-1:0] next_ptr(logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full        = (count_q == CntWidth'(Depth));
  assign not_empty_o = (count_q != '0);
  assign head_pc_o   = mem_q[rd_ptr_q];

  // A full queue loses the new entry even when popped in the same cycle
  assign push_ok    = push_i & ~full;
  assign overflow_o = push_i & full;
  assign pop_ok     = pop_i & not_empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= pc_i;
    end
  end

  // The arbiter only pops queues that flag an entry
  pop_not_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> not_empty_o)
    else $error("pop issued to an empty PC queue");

endmodule

// File: source/rr_trace_arbiter.sv
// Round-robin merge of the queue heads onto one registered trace stream
`timescale 1ns/1ps

module rr_trace_arbiter import commit_pkg::*; #(
  parameter  int unsigned NumIn    = DefaultNrCommitPorts,
  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [NumIn-1:0]    req_i,
  input  pc_t  [NumIn-1:0]    head_pc_i,
  output logic [NumIn-1:0]    pop_o,
  output logic                trace_valid_o,
  output pc_t                 trace_pc_o,
  output logic [IdxWidth-1:0] trace_port_o
);

  logic [IdxWidth-1:0] last_q;
  logic [IdxWidth-1:0] gnt_idx;
  logic                gnt_valid;
  logic                trace_valid_q;
  pc_t                 trace_pc_q;
  logic [IdxWidth-1:0] trace_port_q;

  // --------------------------------------------------------------------------
  // Grant
  // --------------------------------------------------------------------------

  // Search starts one past the last granted port
  always_comb begin
    int unsigned cand;
    gnt_valid = 1'b0;
    gnt_idx   = last_q;
    pop_o     = '0;
    for (int unsigned off = 1; off <= NumIn; off++) begin
      cand = (last_q + off) % NumIn;
      if (!gnt_valid && req_i[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = IdxWidth'(cand);
      end
    end
    if (gnt_valid) begin
      pop_o[gnt_idx] = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Trace register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // So that port 0 is searched first
      last_q        <= IdxWidth'(NumIn - 1);
      trace_valid_q <= 1'b0;
    end else begin
      trace_valid_q <= gnt_valid;
      if (gnt_valid) begin
        last_q <= gnt_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_valid) begin
      trace_pc_q   <= head_pc_i[gnt_idx];
      trace_port_q <= gnt_idx;
    end
  end

  assign trace_valid_o = trace_valid_q;
  assign trace_pc_o    = trace_pc_q;
  assign trace_port_o  = trace_port_q;

  pop_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(pop_o))
    else $error("more than one PC queue popped in a cycle");

  pop_requested_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pop_o & ~req_i) == '0)
    else $error("pop issued to a port without a request");

endmodule

// File: source/perf_counters.sv
// Retire, exception, return and trace-drop counters with CSR-style access
`timescale 1ns/1ps

module perf_counters import perf_pkg::*; #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     debug_mode_i,
  input  logic                     eret_i,
  input  logic [NrCommitPorts-1:0] commit_ack_i,
  input  logic [NrCommitPorts-1:0] commit_ex_valid_i,
  input  logic [NrCommitPorts-1:0] overflow_i,
  input  perf_addr_e               addr_i,
  input  logic                     we_i,
  input  perf_cnt_t                wdata_i,
  output perf_cnt_t                rdata_o
);

  localparam int unsigned NrCounters = int'(PERF_TRACE_DROP) + 1;
  localparam int unsigned SumWidth   = $clog2(NrCommitPorts + 1);

  perf_cnt_t [NrCounters-1:0] cnt_q;
  perf_cnt_t [NrCounters-1:0] cnt_d;
  perf_cnt_t [NrCounters-1:0] incr;
  logic      [SumWidth-1:0]   nr_instret;
  logic      [SumWidth-1:0]   nr_exception;
  logic      [SumWidth-1:0]   nr_drop;
  logic                       addr_valid;

  assign addr_valid = (addr_i <= PERF_TRACE_DROP);

  // --------------------------------------------------------------------------
  // Events per cycle
  // --------------------------------------------------------------------------

  always_comb begin
    nr_instret   = '0;
    nr_exception = '0;
    nr_drop      = '0;
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      nr_instret   = nr_instret + SumWidth'(commit_ack_i[p] & ~commit_ex_valid_i[p]);
      nr_exception = nr_exception + SumWidth'(commit_ack_i[p] & commit_ex_valid_i[p]);
      nr_drop      = nr_drop + SumWidth'(overflow_i[p]);
    end
  end

  always_comb begin
    incr                  = '0;
    incr[PERF_CYCLE]      = perf_cnt_t'(1);
    incr[PERF_INSTRET]    = perf_cnt_t'(nr_instret);
    incr[PERF_EXCEPTION]  = perf_cnt_t'(nr_exception);
    incr[PERF_ERET]       = perf_cnt_t'(eret_i);
    incr[PERF_TRACE_DROP] = perf_cnt_t'(nr_drop);
  end

  // --------------------------------------------------------------------------
  // Update and access
  // --------------------------------------------------------------------------

  always_comb begin
    cnt_d = cnt_q;
    // Frozen while the hart sits in debug mode
    if (!debug_mode_i) begin
      for (int unsigned i = 0; i < NrCounters; i++) begin
        cnt_d[i] = cnt_q[i] + incr[i];
      end
    end
    // Software write wins over this cycle's events
    if (we_i && addr_valid) begin
      cnt_d[addr_i] = wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Unused addresses read as zero
  always_comb begin
    rdata_o = '0;
    if (addr_valid) begin
      rdata_o = cnt_q[addr_i];
    end
  end

  addr_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> !$isunknown(addr_i))
    else $error("counter write with an unknown address");

endmodule

// File: source/commit_trace_top.sv
// Commit trace top level with per-port PC queues, trace arbiter and counters
`timescale 1ns/1ps

module commit_trace_top import commit_pkg::*, perf_pkg::*; #(
  parameter  int unsigned NrCommitPorts = DefaultNrCommitPorts,
  parameter  int unsigned PcQueueDepth  = DefaultPcQueueDepth,
  localparam int unsigned PortIdxWidth  = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      debug_mode_i,
  input  logic                      eret_i,
  // Commit stage
  input  logic [NrCommitPorts-1:0]  commit_ack_i,
  input  logic [NrCommitPorts-1:0]  commit_ex_valid_i,
  input  pc_t  [NrCommitPorts-1:0]  commit_pc_i,
  // Counter access
  input  logic                      perf_we_i,
  input  perf_addr_e                perf_addr_i,
  input  perf_cnt_t                 perf_wdata_i,
  output perf_cnt_t                 perf_rdata_o,
  // Merged PC trace, always accepted
  output logic                      trace_valid_o,
  output pc_t                       trace_pc_o,
  output logic [PortIdxWidth-1:0]   trace_port_o
);

  logic [NrCommitPorts-1:0] push;
  logic [NrCommitPorts-1:0] pop;
  logic [NrCommitPorts-1:0] not_empty;
  logic [NrCommitPorts-1:0] overflow;
  pc_t  [NrCommitPorts-1:0] head_pc;

  // Only cleanly retired instructions are traced
  assign push = commit_ack_i & ~commit_ex_valid_i;

  // --------------------------------------------------------------------------
  // PC queues, one per commit port
  // --------------------------------------------------------------------------

  for (genvar p = 0; p < NrCommitPorts; p++) begin : gen_pc_queue
    pc_queue #(
      .Depth       ( PcQueueDepth   )
    ) pc_queue_inst (
      .clk_i       ( clk_i          ),
      .rst_ni      ( rst_ni         ),
      .push_i      ( push[p]        ),
      .pc_i        ( commit_pc_i[p] ),
      .pop_i       ( pop[p]         ),
      .head_pc_o   ( head_pc[p]     ),
      .not_empty_o ( not_empty[p]   ),
      .overflow_o  ( overflow[p]    )
    );
  end

  // --------------------------------------------------------------------------
  // Trace merge
  // --------------------------------------------------------------------------

  rr_trace_arbiter #(
    .NumIn         ( NrCommitPorts )
  ) rr_trace_arbiter_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .req_i         ( not_empty     ),
    .head_pc_i     ( head_pc       ),
    .pop_o         ( pop           ),
    .trace_valid_o ( trace_valid_o ),
    .trace_pc_o    ( trace_pc_o    ),
    .trace_port_o  ( trace_port_o  )
  );

  // --------------------------------------------------------------------------
  // Performance counters
  // --------------------------------------------------------------------------

  perf_counters #(
    .NrCommitPorts     ( NrCommitPorts     )
  ) perf_counters_inst (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .debug_mode_i      ( debug_mode_i      ),
    .eret_i            ( eret_i            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .overflow_i        ( overflow          ),
    .addr_i            ( perf_addr_i       ),
    .we_i              ( perf_we_i         ),
    .wdata_i           ( perf_wdata_i      ),
    .rdata_o           ( perf_rdata_o      )
  );

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and active-low reset source
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// File: sim/tb_commit_trace.sv
// Testbench for the commit trace top level with trace and counter reference model
`timescale 1ns/1ps

module tb_commit_trace import commit_pkg::*, perf_pkg::*; #(
  parameter int unsigned NrPorts    = DefaultNrCommitPorts,
  parameter int unsigned QueueDepth = 8
);

  localparam int unsigned Seed         = 32'h6dc2_477d;
  localparam int unsigned ResetCycles  = 3;
  localparam int unsigned LightCycles  = 300;
  localparam int unsigned BurstCycles  = 25;
  localparam int unsigned GapCycles    = 5;
  localparam int unsigned NrBursts     = 4;
  localparam int unsigned ExcCycles    = 200;
  localparam int unsigned WriteCycles  = 60;
  localparam int unsigned IdleWait     = 10;
  localparam int unsigned DebugCycles  = 100;
  localparam int unsigned NrTests      = 6;
  // Reads, writes and the tail of the drain in each test
  localparam int unsigned TestOverhead = 40;
  localparam int unsigned StimCycles   = LightCycles + NrBursts * (BurstCycles + GapCycles)
                                         + ExcCycles + WriteCycles + IdleWait + DebugCycles
                                         + BurstCycles;
  localparam int unsigned TimeoutCycles = ResetCycles + StimCycles + NrTests * TestOverhead
                                          + 2 * NrPorts * QueueDepth;
  localparam int unsigned NrCounters   = int'(PERF_TRACE_DROP) + 1;
  localparam int unsigned PortW        = (NrPorts > 1) ? $clog2(NrPorts) : 1;

  logic               clk;
  logic               rst_n;
  logic               debug_mode;
  logic               eret;
  logic [NrPorts-1:0] commit_ack;
  logic [NrPorts-1:0] commit_ex;
  pc_t  [NrPorts-1:0] commit_pc;
  logic               perf_we;
  perf_addr_e         perf_addr;
  perf_cnt_t          perf_wdata;
  perf_cnt_t          perf_rdata;
  logic               trace_valid;
  pc_t                trace_pc;
  logic [PortW-1:0]   trace_port;

  // Reference model state
  pc_t         exp_q [NrPorts][$];
  perf_cnt_t   m_instret;
  perf_cnt_t   m_exception;
  perf_cnt_t   m_eret;
  perf_cnt_t   drop_base;
  int unsigned pushed;
  int unsigned emitted;
  int unsigned pc_seq;
  int unsigned cycle_cnt;
  int unsigned nr_errors;
  int unsigned nr_checks;
  int unsigned nr_tests;
  int unsigned nr_failed;
  int unsigned errors_at_start;
  bit          lossy;
  string       test_name;

  tb_clock_gen #(
    .ResetCycles ( ResetCycles )
  ) tb_clock_gen_inst (
    .clk_o       ( clk         ),
    .rst_no      ( rst_n       )
  );

  commit_trace_top #(
    .NrCommitPorts     ( NrPorts     ),
    .PcQueueDepth      ( QueueDepth  )
  ) commit_trace_top_inst (
    .clk_i             ( clk         ),
    .rst_ni            ( rst_n       ),
    .debug_mode_i      ( debug_mode  ),
    .eret_i            ( eret        ),
    .commit_ack_i      ( commit_ack  ),
    .commit_ex_valid_i ( commit_ex   ),
    .commit_pc_i       ( commit_pc   ),
    .perf_we_i         ( perf_we     ),
    .perf_addr_i       ( perf_addr   ),
    .perf_wdata_i      ( perf_wdata  ),
    .perf_rdata_o      ( perf_rdata  ),
    .trace_valid_o     ( trace_valid ),
    .trace_pc_o        ( trace_pc    ),
    .trace_port_o      ( trace_port  )
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(string what, perf_cnt_t expected, perf_cnt_t actual);
    nr_checks++;
    assert (expected === actual) else begin
      $display("Fail %s: %s expected %0h actual %0h", test_name, what, expected, actual);
      nr_errors++;
    end
  endtask

  task automatic begin_test(string name);
    test_name       = name;
    errors_at_start = nr_errors;
  endtask

  task automatic end_test();
    nr_tests++;
    if (nr_errors == errors_at_start) begin
      $display("%-16s ok", test_name);
    end else begin
      nr_failed++;
      $display("%-16s failed with %0d errors", test_name, nr_errors - errors_at_start);
    end
  endtask

  // Unique PC with a running sequence number in the low word
  function automatic pc_t new_pc();
    pc_seq++;
    return {$urandom(), pc_seq};
  endfunction

  task automatic read_counter(perf_addr_e addr, output perf_cnt_t value);
    perf_addr = addr;
    @(negedge clk);
    value = perf_rdata;
    tick();
  endtask

  task automatic write_counter(perf_addr_e addr, perf_cnt_t value);
    perf_we    = 1'b1;
    perf_addr  = addr;
    perf_wdata = value;
    tick();
    perf_we    = 1'b0;
  endtask

  // Random commits on each port per cycle; single keeps at most one port active
  task automatic drive_commits(int unsigned cycles, int unsigned ack_pct,
                               int unsigned ex_pct, int unsigned eret_pct, bit single);
    int unsigned pick;
    for (int unsigned c = 0; c < cycles; c++) begin
      pick = $urandom_range(NrPorts - 1);
      for (int unsigned p = 0; p < NrPorts; p++) begin
        commit_ack[p] = ($urandom_range(99) < ack_pct) && (!single || p == pick);
        commit_ex[p]  = commit_ack[p] && ($urandom_range(99) < ex_pct);
        commit_pc[p]  = new_pc();
        if (commit_ack[p] && !commit_ex[p]) begin
          exp_q[p].push_back(commit_pc[p]);
          pushed++;
        end
        if (!debug_mode && commit_ack[p]) begin
          if (commit_ex[p]) begin
            m_exception++;
          end else begin
            m_instret++;
          end
        end
      end
      eret = ($urandom_range(99) < eret_pct);
      if (!debug_mode && eret) begin
        m_eret++;
      end
      tick();
    end
    commit_ack = '0;
    commit_ex  = '0;
    eret       = 1'b0;
  endtask

  // Queues are empty once the trace has been idle for two cycles
  task automatic drain_trace();
    int unsigned idle;
    idle = 0;
    while (idle < 2) begin
      @(negedge clk);
      idle = trace_valid ? 0 : idle + 1;
      tick();
    end
  endtask

  task automatic start_commit_test();
    pushed  = 0;
    emitted = 0;
    read_counter(PERF_TRACE_DROP, drop_base);
  endtask

  task automatic finish_commit_test(bit strict);
    perf_cnt_t drops;
    drain_trace();
    read_counter(PERF_TRACE_DROP, drops);
    drops = drops - drop_base;
    check_value("emitted plus dropped", perf_cnt_t'(pushed), perf_cnt_t'(emitted) + drops);
    if (strict) begin
      check_value("dropped", '0, drops);
    end
    for (int unsigned p = 0; p < NrPorts; p++) begin
      exp_q[p].delete();
    end
  endtask

  // --------------------------------------------------------------------------
  // Trace monitor and timeout
  // --------------------------------------------------------------------------

  always @(negedge clk) begin : trace_monitor
    if (rst_n && trace_valid) begin
      emitted++;
      // Entries lost to a full queue never show up
      while (lossy && exp_q[trace_port].size() > 0 && exp_q[trace_port][0] != trace_pc) begin
        void'(exp_q[trace_port].pop_front());
      end
      nr_checks++;
      assert (exp_q[trace_port].size() != 0) else begin
        $display("%s: port %0d traced PC %0h that was never pushed there",
                 test_name, trace_port, trace_pc);
        nr_errors++;
      end
      if (exp_q[trace_port].size() != 0) begin
        check_value($sformatf("trace PC on port %0d", trace_port),
                    exp_q[trace_port].pop_front(), trace_pc);
      end
    end
  end

  always @(posedge clk) begin : timeout_watch
    cycle_cnt++;
    if (cycle_cnt > TimeoutCycles) begin
      $display("Run stopped after %0d cycles, the tests did not finish", TimeoutCycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin : main
    perf_cnt_t value;
    perf_cnt_t wval;
    perf_cnt_t frozen [NrCounters];
    void'($urandom(Seed));
    debug_mode  = 1'b1;
    eret        = 1'b0;
    commit_ack  = '0;
    commit_ex   = '0;
    commit_pc   = '0;
    perf_we     = 1'b0;
    perf_addr   = PERF_CYCLE;
    perf_wdata  = '0;
    m_instret   = '0;
    m_exception = '0;
    m_eret      = '0;
    pc_seq      = 0;
    cycle_cnt   = 0;
    nr_errors   = 0;
    nr_checks   = 0;
    nr_tests    = 0;
    nr_failed   = 0;
    lossy       = 1'b0;
    @(posedge rst_n);

    // Debug mode keeps the cycle counter at zero while reading
    begin_test("reset state");
    check_value("trace valid", '0, perf_cnt_t'(trace_valid));
    for (int a = 0; a < int'(NrCounters); a++) begin
      read_counter(perf_addr_e'(a), value);
      check_value($sformatf("counter %0d", a), '0, value);
    end
    debug_mode = 1'b0;
    end_test();

    begin_test("light commits");
    lossy = 1'b0;
    start_commit_test();
    drive_commits(LightCycles, 60, 0, 0, 1'b1);
    finish_commit_test(1'b1);
    end_test();

    begin_test("dense bursts");
    lossy = 1'b1;
    start_commit_test();
    repeat (NrBursts) begin
      drive_commits(BurstCycles, 90, 0, 0, 1'b0);
      drive_commits(GapCycles, 0, 0, 0, 1'b0);
    end
    finish_commit_test(1'b0);
    end_test();

    begin_test("exceptions");
    start_commit_test();
    drive_commits(ExcCycles, 40, 35, 15, 1'b0);
    finish_commit_test(1'b0);
    read_counter(PERF_INSTRET, value);
    check_value("instret", m_instret, value);
    read_counter(PERF_EXCEPTION, value);
    check_value("exception", m_exception, value);
    read_counter(PERF_ERET, value);
    check_value("eret", m_eret, value);
    end_test();

    begin_test("counter writes");
    wval = {$urandom(), $urandom()};
    write_counter(PERF_CYCLE, wval);
    repeat (IdleWait) tick();
    read_counter(PERF_CYCLE, value);
    check_value("cycle after write", wval + IdleWait, value);
    wval = {$urandom(), $urandom()};
    write_counter(PERF_INSTRET, wval);
    m_instret = wval;
    start_commit_test();
    drive_commits(WriteCycles, 50, 20, 10, 1'b0);
    finish_commit_test(1'b0);
    read_counter(PERF_INSTRET, value);
    check_value("instret after write", m_instret, value);
    read_counter(PERF_ERET, value);
    check_value("eret", m_eret, value);
    wval = {$urandom(), $urandom()};
    write_counter(PERF_TRACE_DROP, wval);
    read_counter(PERF_TRACE_DROP, value);
    check_value("trace drop after write", wval, value);
    for (int a = NrCounters; a < 8; a++) begin
      read_counter(perf_addr_e'(a), value);
      check_value($sformatf("unused address %0d", a), '0, value);
    end
    end_test();

    begin_test("debug freeze");
    lossy      = 1'b0;
    debug_mode = 1'b1;
    tick();
    for (int a = 0; a < int'(NrCounters); a++) begin
      read_counter(perf_addr_e'(a), frozen[a]);
    end
    start_commit_test();
    drive_commits(DebugCycles, 60, 20, 20, 1'b1);
    finish_commit_test(1'b1);
    // Full-rate burst so that the queues overflow while the counters are frozen
    lossy = 1'b1;
    drive_commits(BurstCycles, 100, 0, 0, 1'b0);
    drain_trace();
    for (int unsigned p = 0; p < NrPorts; p++) begin
      exp_q[p].delete();
    end
    for (int a = 0; a < int'(NrCounters); a++) begin
      read_counter(perf_addr_e'(a), value);
      check_value($sformatf("frozen counter %0d", a), frozen[a], value);
    end
    debug_mode = 1'b0;
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             nr_tests, nr_failed, nr_checks, nr_errors);
    if (nr_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: list.f
source/commit_pkg.sv
source/perf_pkg.sv
source/pc_queue.sv
source/rr_trace_arbiter.sv
source/perf_counters.sv
source/commit_trace_top.sv
sim/tb_clock_gen.sv
sim/tb_commit_trace.sv

// File: Makefile
# Verilator build and run of the commit trace testbench

VERILATOR ?= verilator
TOP       ?= tb_commit_trace
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(wildcard source/*.sv) $(wildcard sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The log decides the result, not the exit status of the simulator
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
